// File: rtl/axi_mem_pkg.sv
// AXI4 slave memory channel types: payload structs, response and burst codes
`default_nettype none

package axi_mem_pkg;

  ////////////////////////////////////////////////////////////
  // Field widths
  ////////////////////////////////////////////////////////////

  localparam int ID_W   = 4;           // Transaction ID
  localparam int ADDR_W = 32;          // Byte address
  localparam int LEN_W  = 4;           // Burst length, beats minus one
  localparam int DATA_W = 32;          // One word per beat
  localparam int STRB_W = DATA_W / 8;  // One strobe bit per byte lane

  ////////////////////////////////////////////////////////////
  // Codes
  ////////////////////////////////////////////////////////////

  typedef logic [ID_W-1:0] axi_id_t;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,  // Normal access done
    RESP_SLVERR = 2'b10   // Start address outside the array
  } axi_resp_t;

  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,  // Same word every beat
    BURST_INCR  = 2'b01,  // Next word every beat
    BURST_WRAP  = 2'b10   // Handled like INCR
  } axi_burst_t;

  ////////////////////////////////////////////////////////////
  // Channel payloads
  ////////////////////////////////////////////////////////////

  // Shared by AW and AR
  typedef struct packed {
    axi_id_t           id;
    logic [ADDR_W-1:0] addr;   // Bits 1:0 ignored
    logic [LEN_W-1:0]  len;
    axi_burst_t        burst;
  } axi_addr_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;   // Byte lane enables
    logic              last;   // Ends the write burst
  } axi_w_t;

  typedef struct packed {
    axi_id_t   id;             // Echo of AW id
    axi_resp_t resp;
  } axi_b_t;

  typedef struct packed {
    axi_id_t           id;     // Echo of AR id
    logic [DATA_W-1:0] data;
    axi_resp_t         resp;
    logic              last;   // Set on beat len+1
  } axi_r_t;

endpackage

`default_nettype wire

// File: rtl/axi_chan_slice.sv
// Channel register slice: two-entry valid/ready skid buffer for any payload type
`default_nettype none
`timescale 1ns/100ps

module axi_chan_slice #(
  parameter type payload_t = logic
) (
  input  logic     aclk,
  input  logic     aresetn,
  input  payload_t in,
  input  logic     in_valid,
  output logic     in_ready,
  output payload_t out,
  output logic     out_valid,
  input  logic     out_ready
);

  payload_t main_q;        // Entry offered at the output
  payload_t skid_q;        // Catches a beat while output stalls
  logic     main_valid_q;
  logic     skid_valid_q;
  logic     main_load;

  assign main_load = out_ready || !main_valid_q;  // Main empty or draining now
  assign in_ready  = !skid_valid_q;               // Room while fewer than two held
  assign out       = main_q;
  assign out_valid = main_valid_q;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      main_valid_q <= 1'b0;
      skid_valid_q <= 1'b0;
    end else if (main_load) begin
      main_valid_q <= skid_valid_q || in_valid;  // Skid first, else new beat
      skid_valid_q <= 1'b0;
    end else if (in_valid && in_ready) begin
      skid_valid_q <= 1'b1;                      // Output stalled, park it
    end
  end

  always_ff @(posedge aclk) begin
    if (main_load) begin
      main_q <= skid_valid_q ? skid_q : in;
    end else if (in_valid && in_ready) begin
      skid_q <= in;
    end
  end

  // A stalled beat must reach the consumer unchanged
  a_out_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    out_valid && !out_ready |=> out_valid && $stable(out));

endmodule

`default_nettype wire

// File: rtl/axi_mem_array.sv
// Word memory: byte-strobed write port and registered read port that holds
`default_nettype none
`timescale 1ns/100ps

module axi_mem_array #(
  parameter int MEM_WORDS = 256
) (
  input  logic                           aclk,
  input  logic                           wr_en,
  input  logic [$clog2(MEM_WORDS)-1:0]   wr_index,
  input  logic [axi_mem_pkg::DATA_W-1:0] wr_data,
  input  logic [axi_mem_pkg::STRB_W-1:0] wr_strb,
  input  logic                           rd_en,
  input  logic [$clog2(MEM_WORDS)-1:0]   rd_index,
  output logic [axi_mem_pkg::DATA_W-1:0] rd_data
);

  import axi_mem_pkg::*;

  logic [DATA_W-1:0] mem_q [MEM_WORDS];  // Contents undefined after reset

  ////////////////////////////////////////////////////////////
  // Write port
  ////////////////////////////////////////////////////////////

  // Only enabled lanes change, others keep the stored byte
  always_ff @(posedge aclk) begin
    if (wr_en) begin
      for (int i = 0; i < STRB_W; i++) begin
        if (wr_strb[i]) begin
          mem_q[wr_index][8*i +: 8] <= wr_data[8*i +: 8];
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Read port
  ////////////////////////////////////////////////////////////

  always_ff @(posedge aclk) begin
    if (rd_en) begin
      rd_data <= mem_q[rd_index];  // Holds while rd_en low
    end
  end

endmodule

`default_nettype wire

// File: rtl/axi_mem_write.sv
// Write burst engine: takes AW, writes W beats into the array, returns B
`default_nettype none
`timescale 1ns/100ps

module axi_mem_write #(
  parameter int MEM_WORDS = 256
) (
  input  logic                           aclk,
  input  logic                           aresetn,
  input  axi_mem_pkg::axi_addr_t         aw,
  input  logic                           aw_valid,
  output logic                           aw_ready,
  input  axi_mem_pkg::axi_w_t            w,
  input  logic                           w_valid,
  output logic                           w_ready,
  output axi_mem_pkg::axi_b_t            b,
  output logic                           b_valid,
  input  logic                           b_ready,
  output logic                           wr_en,
  output logic [$clog2(MEM_WORDS)-1:0]   wr_index,
  output logic [axi_mem_pkg::DATA_W-1:0] wr_data,
  output logic [axi_mem_pkg::STRB_W-1:0] wr_strb
);

  import axi_mem_pkg::*;

  localparam int IDX_W  = $clog2(MEM_WORDS);
  localparam int WORD_W = ADDR_W - 2;  // Word address, byte bits dropped

  typedef enum logic [1:0] {
    WR_IDLE,  // Waiting for AW
    WR_DATA,  // Taking W beats
    WR_RESP   // Holding B
  } wr_state_t;

  wr_state_t         state_q;
  axi_id_t           id_q;
  axi_burst_t        burst_q;
  logic [WORD_W-1:0] word_q;     // Current beat word address
  logic              err_q;      // Start beyond the array
  logic              aw_hs;
  logic              w_hs;
  logic              b_hs;
  logic              in_range;

  ////////////////////////////////////////////////////////////
  // Handshakes
  ////////////////////////////////////////////////////////////

  assign aw_ready = (state_q == WR_IDLE);
  assign w_ready  = (state_q == WR_DATA);
  assign b_valid  = (state_q == WR_RESP);
  assign aw_hs    = aw_valid && aw_ready;
  assign w_hs     = w_valid && w_ready;
  assign b_hs     = b_valid && b_ready;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state_q <= WR_IDLE;
    end else begin
      case (state_q)
        WR_IDLE: if (aw_hs) state_q <= WR_DATA;
        WR_DATA: if (w_hs && w.last) state_q <= WR_RESP;  // W last ends the burst
        WR_RESP: if (b_hs) state_q <= WR_IDLE;
        default: state_q <= WR_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Burst context
  ////////////////////////////////////////////////////////////

  always_ff @(posedge aclk) begin
    if (aw_hs) begin
      id_q    <= aw.id;
      burst_q <= aw.burst;
      word_q  <= aw.addr[ADDR_W-1:2];
      err_q   <= aw.addr[ADDR_W-1:2] >= WORD_W'(MEM_WORDS);
    end else if (w_hs && burst_q != BURST_FIXED) begin
      word_q  <= word_q + 1'b1;  // INCR and WRAP step
    end
  end

  // INCR running off the end stores nothing
  assign in_range = word_q < WORD_W'(MEM_WORDS);

  ////////////////////////////////////////////////////////////
  // Array write port and response
  ////////////////////////////////////////////////////////////

  assign wr_en    = w_hs && !err_q && in_range;
  assign wr_index = word_q[IDX_W-1:0];
  assign wr_data  = w.data;
  assign wr_strb  = w.strb;

  assign b.id   = id_q;
  assign b.resp = err_q ? RESP_SLVERR : RESP_OKAY;

  a_wr_in_data: assert property (@(posedge aclk) disable iff (!aresetn)
    wr_en |-> state_q == WR_DATA);

endmodule

`default_nettype wire

// File: rtl/axi_mem_read.sv
// Read burst engine: takes AR, issues array reads, returns R beats under back-pressure
`default_nettype none
`timescale 1ns/100ps

module axi_mem_read #(
  parameter int MEM_WORDS = 256
) (
  input  logic                           aclk,
  input  logic                           aresetn,
  input  axi_mem_pkg::axi_addr_t         ar,
  input  logic                           ar_valid,
  output logic                           ar_ready,
  output axi_mem_pkg::axi_r_t            r,
  output logic                           r_valid,
  input  logic                           r_ready,
  output logic                           rd_en,
  output logic [$clog2(MEM_WORDS)-1:0]   rd_index,
  input  logic [axi_mem_pkg::DATA_W-1:0] rd_data
);

  import axi_mem_pkg::*;

  localparam int IDX_W  = $clog2(MEM_WORDS);
  localparam int WORD_W = ADDR_W - 2;

  typedef enum logic {
    RD_IDLE,  // Waiting for AR
    RD_BUSY   // Issuing beats
  } rd_state_t;

  rd_state_t         state_q;
  axi_id_t           id_q;
  axi_burst_t        burst_q;
  logic [WORD_W-1:0] word_q;
  logic [LEN_W-1:0]  len_q;
  logic [LEN_W-1:0]  cnt_q;       // Beats issued so far
  logic              err_q;
  logic              ar_hs;
  logic              slot_free;   // R register empty or draining
  logic              issue_last;

  // R output register, data itself comes from the array register
  axi_id_t           r_id_q;
  axi_resp_t         r_resp_q;
  logic              r_last_q;
  logic              r_zero_q;    // Beat outside the array

  assign ar_ready   = (state_q == RD_IDLE);
  assign ar_hs      = ar_valid && ar_ready;
  assign slot_free  = !r_valid || r_ready;
  assign rd_en      = (state_q == RD_BUSY) && slot_free;
  assign rd_index   = word_q[IDX_W-1:0];
  assign issue_last = (cnt_q == len_q);

  ////////////////////////////////////////////////////////////
  // Burst control
  ////////////////////////////////////////////////////////////

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state_q <= RD_IDLE;
    end else begin
      case (state_q)
        RD_IDLE: if (ar_hs) state_q <= RD_BUSY;
        RD_BUSY: if (rd_en && issue_last) state_q <= RD_IDLE;
        default: state_q <= RD_IDLE;
      endcase
    end
  end

  always_ff @(posedge aclk) begin
    if (ar_hs) begin
      id_q    <= ar.id;
      burst_q <= ar.burst;
      len_q   <= ar.len;
      cnt_q   <= '0;
      word_q  <= ar.addr[ADDR_W-1:2];
      err_q   <= ar.addr[ADDR_W-1:2] >= WORD_W'(MEM_WORDS);
    end else if (rd_en) begin
      cnt_q   <= cnt_q + 1'b1;
      if (burst_q != BURST_FIXED) begin
        word_q <= word_q + 1'b1;  // WRAP falls in here too
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // R channel
  ////////////////////////////////////////////////////////////

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      r_valid <= 1'b0;
    end else if (rd_en) begin
      r_valid <= 1'b1;   // Data lands one cycle after issue
    end else if (r_ready) begin
      r_valid <= 1'b0;
    end
  end

  always_ff @(posedge aclk) begin
    if (rd_en) begin
      r_id_q   <= id_q;  // Kept per beat, next AR may overwrite id_q
      r_last_q <= issue_last;
      r_resp_q <= err_q ? RESP_SLVERR : RESP_OKAY;
      r_zero_q <= word_q >= WORD_W'(MEM_WORDS);
    end
  end

  assign r.id   = r_id_q;
  assign r.data = r_zero_q ? '0 : rd_data;  // Array holds while rd_en low
  assign r.resp = r_resp_q;
  assign r.last = r_last_q;

  a_r_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    r_valid && !r_ready |=> $stable(r));

  // Nothing more is issued right after the last beat
  a_no_beat_after_last: assert property (@(posedge aclk) disable iff (!aresetn)
    rd_en && issue_last |=> !rd_en);

endmodule

`default_nettype wire

// File: rtl/axi_mem_slave.sv
// AXI4 slave memory top: address slices, write and read engines, word array
`default_nettype none
`timescale 1ns/100ps

module axi_mem_slave #(
  parameter int MEM_WORDS = 256
) (
  input  logic                   aclk,
  input  logic                   aresetn,
  input  axi_mem_pkg::axi_addr_t aw,
  input  logic                   aw_valid,
  output logic                   aw_ready,
  input  axi_mem_pkg::axi_w_t    w,
  input  logic                   w_valid,
  output logic                   w_ready,
  output axi_mem_pkg::axi_b_t    b,
  output logic                   b_valid,
  input  logic                   b_ready,
  input  axi_mem_pkg::axi_addr_t ar,
  input  logic                   ar_valid,
  output logic                   ar_ready,
  output axi_mem_pkg::axi_r_t    r,
  output logic                   r_valid,
  input  logic                   r_ready
);

  import axi_mem_pkg::*;

  localparam int IDX_W = $clog2(MEM_WORDS);

  axi_addr_t         aw_q;         // AW after the slice
  logic              aw_q_valid;
  logic              aw_q_ready;
  axi_addr_t         ar_q;         // AR after the slice
  logic              ar_q_valid;
  logic              ar_q_ready;
  logic              wr_en;
  logic [IDX_W-1:0]  wr_index;
  logic [DATA_W-1:0] wr_data;
  logic [STRB_W-1:0] wr_strb;
  logic              rd_en;
  logic [IDX_W-1:0]  rd_index;
  logic [DATA_W-1:0] rd_data;

  ////////////////////////////////////////////////////////////
  // Address slices
  ////////////////////////////////////////////////////////////

  axi_chan_slice #(.payload_t(axi_addr_t)) i_aw_slice (
    .aclk, .aresetn,
    .in       (aw),       .in_valid (aw_valid),   .in_ready  (aw_ready),
    .out      (aw_q),     .out_valid(aw_q_valid), .out_ready (aw_q_ready)
  );

  axi_chan_slice #(.payload_t(axi_addr_t)) i_ar_slice (
    .aclk, .aresetn,
    .in       (ar),       .in_valid (ar_valid),   .in_ready  (ar_ready),
    .out      (ar_q),     .out_valid(ar_q_valid), .out_ready (ar_q_ready)
  );

  ////////////////////////////////////////////////////////////
  // Engines and array
  ////////////////////////////////////////////////////////////

  axi_mem_write #(.MEM_WORDS(MEM_WORDS)) i_axi_mem_write (
    .aclk, .aresetn,
    .aw       (aw_q),     .aw_valid (aw_q_valid), .aw_ready  (aw_q_ready),
    .w        (w),        .w_valid  (w_valid),    .w_ready   (w_ready),
    .b        (b),        .b_valid  (b_valid),    .b_ready   (b_ready),
    .wr_en    (wr_en),    .wr_index (wr_index),
    .wr_data  (wr_data),  .wr_strb  (wr_strb)
  );

  axi_mem_read #(.MEM_WORDS(MEM_WORDS)) i_axi_mem_read (
    .aclk, .aresetn,
    .ar       (ar_q),     .ar_valid (ar_q_valid), .ar_ready  (ar_q_ready),
    .r        (r),        .r_valid  (r_valid),    .r_ready   (r_ready),
    .rd_en    (rd_en),    .rd_index (rd_index),   .rd_data   (rd_data)
  );

  axi_mem_array #(.MEM_WORDS(MEM_WORDS)) i_axi_mem_array (
    .aclk,
    .wr_en    (wr_en),    .wr_index (wr_index),
    .wr_data  (wr_data),  .wr_strb  (wr_strb),
    .rd_en    (rd_en),    .rd_index (rd_index),   .rd_data   (rd_data)
  );

endmodule

`default_nettype wire

// File: testbench/tb_axi_mem_slave.sv
// Testbench for the AXI4 slave memory: directed bursts checked against a shadow memory
`default_nettype none
`timescale 1ns/100ps

module tb_axi_mem_slave;

  import axi_mem_pkg::*;

  localparam int MEM_WORDS = 256;
  localparam int TIMEOUT   = 200;   // Cycles per handshake wait

  logic              aclk;
  logic              aresetn;
  axi_addr_t         aw;
  logic              aw_valid;
  logic              aw_ready;
  axi_w_t            w;
  logic              w_valid;
  logic              w_ready;
  axi_b_t            b;
  logic              b_valid;
  logic              b_ready;
  axi_addr_t         ar;
  logic              ar_valid;
  logic              ar_ready;
  axi_r_t            r;
  logic              r_valid;
  logic              r_ready;

  logic [31:0]       shadow [MEM_WORDS];   // Expected memory contents
  logic [31:0]       lfsr_q = 32'h7fe50db8;
  string             test_name;
  int                test_cnt  = 0;
  int                check_cnt = 0;
  int                err_cnt   = 0;

  axi_mem_slave #(.MEM_WORDS(MEM_WORDS)) i_axi_mem_slave (
    .aclk, .aresetn,
    .aw, .aw_valid, .aw_ready, .w, .w_valid, .w_ready, .b, .b_valid, .b_ready,
    .ar, .ar_valid, .ar_ready, .r, .r_valid, .r_ready
  );

  always #50 aclk = ~aclk;   // 100 ns period

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  // Galois LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v      = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? (lfsr_q >> 1) ^ 32'h8020_0003 : lfsr_q >> 1;
    end
    return v;
  endfunction

  function automatic axi_addr_t make_addr(input axi_id_t id, input int unsigned word,
                                          input int len, input axi_burst_t burst);
    axi_addr_t a;
    a.id    = id;
    a.addr  = 32'(word * 4);   // Byte address of the word
    a.len   = 4'(len);
    a.burst = burst;
    return a;
  endfunction

  task automatic abort_run(input string why);
    $display("Error in %s: %s", test_name, why);
    $display("TB FAILED");
    $finish;
  endtask

  task automatic check(input string what, input logic [31:0] expected, input logic [31:0] actual);
    check_cnt++;
    if (expected !== actual) begin
      err_cnt++;
      $display("Fail %s: %s expected %h actual %h", test_name, what, expected, actual);
    end
  endtask

  task automatic finish_test();
    test_cnt++;
    $display("Test %s finished, %0d errors so far", test_name, err_cnt);
  endtask

  task automatic push_aw(input axi_addr_t a);
    int n;
    aw       = a;
    aw_valid = 1'b1;
    n        = 0;
    while (!aw_ready) begin
      if (n == TIMEOUT) abort_run("AW handshake timed out");
      else n++;
      @(negedge aclk);
    end
    @(negedge aclk);             // Transfer took place at the edge in between
    aw_valid = 1'b0;
  endtask

  task automatic push_ar(input axi_addr_t a);
    int n;
    ar       = a;
    ar_valid = 1'b1;
    n        = 0;
    while (!ar_ready) begin
      if (n == TIMEOUT) abort_run("AR handshake timed out");
      else n++;
      @(negedge aclk);
    end
    @(negedge aclk);
    ar_valid = 1'b0;
  endtask

  // Sends len+1 random beats and applies them to the shadow memory
  task automatic push_w(input int unsigned word, input int len, input axi_burst_t burst,
                        input logic [3:0] strb);
    int          n;
    int unsigned idx;
    idx = word;
    for (int beat = 0; beat <= len; beat++) begin
      w.data  = rand_bits(32);
      w.strb  = strb;
      w.last  = (beat == len);
      w_valid = 1'b1;
      if (word < MEM_WORDS && idx < MEM_WORDS) begin   // Out of range is not stored
        for (int i = 0; i < 4; i++) begin
          if (strb[i]) shadow[idx][8*i +: 8] = w.data[8*i +: 8];
        end
      end
      n = 0;
      while (!w_ready) begin
        if (n == TIMEOUT) abort_run("W handshake timed out");
        else n++;
        @(negedge aclk);
      end
      @(negedge aclk);
      if (burst != BURST_FIXED) idx++;
    end
    w_valid = 1'b0;
  endtask

  task automatic take_b(input axi_id_t id, input axi_resp_t resp);
    int     n;
    axi_b_t got;
    b_ready = 1'b1;
    n       = 0;
    while (!b_valid) begin
      if (n == TIMEOUT) abort_run("B response timed out");
      else n++;
      @(negedge aclk);
    end
    got = b;
    @(negedge aclk);
    b_ready = 1'b0;
    check("b.id", id, got.id);
    check("b.resp", resp, got.resp);
  endtask

  task automatic write_burst(input axi_id_t id, input int unsigned word, input int len,
                             input axi_burst_t burst, input logic [3:0] strb);
    push_aw(make_addr(id, word, len, burst));
    push_w(word, len, burst, strb);
    take_b(id, word >= MEM_WORDS ? RESP_SLVERR : RESP_OKAY);
  endtask

  // Reads one burst, with r_ready from the LFSR when bp is set
  task automatic read_burst(input axi_id_t id, input int unsigned word, input int len,
                            input axi_burst_t burst, input bit bp);
    axi_r_t      got;
    int          beat;
    int          idle;
    int unsigned idx;
    logic [31:0] bit_q;
    bit          done;
    push_ar(make_addr(id, word, len, burst));
    idx  = word;
    beat = 0;
    idle = 0;
    done = 1'b0;
    while (!done) begin
      bit_q   = bp ? rand_bits(1) : 32'd1;
      r_ready = bit_q[0];
      if (r_valid && r_ready) begin
        got  = r;
        idle = 0;
        check("r.data", (word >= MEM_WORDS || idx >= MEM_WORDS) ? 32'd0 : shadow[idx], got.data);
        check("r.id", id, got.id);
        check("r.resp", word >= MEM_WORDS ? RESP_SLVERR : RESP_OKAY, got.resp);
        check("r.last", beat == len, got.last);
        beat++;
        if (burst != BURST_FIXED) idx++;
        done = got.last || beat > len;   // Stops on last or on an extra beat
      end else if (idle == TIMEOUT) begin
        abort_run("R beat timed out");
      end else begin
        idle++;
      end
      @(negedge aclk);
    end
    r_ready = 1'b0;
    check("R beat count", len + 1, beat);
    check("r_valid after last", 1'b0, r_valid);
  endtask

  ////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////

  task automatic test_reset_single();
    test_name = "reset_single";
    repeat (8) begin
      @(negedge aclk);
      check("b_valid in reset", 1'b0, b_valid);
      check("r_valid in reset", 1'b0, r_valid);
    end
    aresetn = 1'b1;
    @(negedge aclk);
    check("b_valid after reset", 1'b0, b_valid);
    check("r_valid after reset", 1'b0, r_valid);
    write_burst(4'h5, 7, 0, BURST_INCR, 4'hf);
    read_burst(4'ha, 7, 0, BURST_INCR, 1'b0);
    finish_test();
  endtask

  task automatic test_byte_strobes();
    int unsigned word;
    test_name = "byte_strobes";
    word      = rand_bits(8);
    write_burst(4'h1, word, 0, BURST_INCR, 4'b1111);
    write_burst(4'h2, word, 0, BURST_INCR, 4'b0001);
    write_burst(4'h3, word, 0, BURST_INCR, 4'b0110);
    write_burst(4'h4, word, 0, BURST_INCR, 4'b1000);
    read_burst(4'h6, word, 0, BURST_INCR, 1'b0);
    finish_test();
  endtask

  task automatic test_incr_backpressure();
    int unsigned word;
    test_name = "incr_backpressure";
    word      = rand_bits(8) % 241;   // All 16 beats in range
    write_burst(4'h7, word, 15, BURST_INCR, 4'hf);
    read_burst(4'h8, word, 15, BURST_INCR, 1'b1);
    finish_test();
  endtask

  task automatic test_fixed_burst();
    int unsigned word;
    test_name = "fixed_burst";
    word      = rand_bits(8);
    write_burst(4'h9, word, 3, BURST_FIXED, 4'hf);   // Last beat wins
    read_burst(4'hb, word, 3, BURST_FIXED, 1'b0);
    finish_test();
  endtask

  task automatic test_out_of_range();
    test_name = "out_of_range";
    write_burst(4'hc, 0, 3, BURST_INCR, 4'hf);
    write_burst(4'h1, 44, 3, BURST_INCR, 4'hf);      // Where 300 lands if truncated
    write_burst(4'hd, 300, 3, BURST_INCR, 4'hf);
    read_burst(4'he, 300, 3, BURST_INCR, 1'b0);
    read_burst(4'hf, 0, 3, BURST_INCR, 1'b0);
    read_burst(4'h2, 44, 3, BURST_INCR, 1'b0);       // 300 must not alias to 44
    finish_test();
  endtask

  task automatic test_queued_ids();
    test_name = "queued_ids";
    push_aw(make_addr(4'h1, 10, 0, BURST_INCR));
    push_aw(make_addr(4'h2, 11, 0, BURST_INCR));
    push_aw(make_addr(4'h3, 12, 0, BURST_INCR));     // Held by the AW slice
    for (int i = 0; i < 3; i++) begin
      push_w(10 + i, 0, BURST_INCR, 4'hf);
      take_b(4'(i + 1), RESP_OKAY);
    end
    read_burst(4'h4, 10, 2, BURST_INCR, 1'b0);
    finish_test();
  endtask

  initial begin
    aclk     = 1'b0;
    aresetn  = 1'b0;
    aw       = '0;
    aw_valid = 1'b0;
    w        = '0;
    w_valid  = 1'b0;
    b_ready  = 1'b0;
    ar       = '0;
    ar_valid = 1'b0;
    r_ready  = 1'b0;
    test_reset_single();
    test_byte_strobes();
    test_incr_backpressure();
    test_fixed_burst();
    test_out_of_range();
    test_queued_ids();
    $display("Tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
rtl/axi_mem_pkg.sv
rtl/axi_chan_slice.sv
rtl/axi_mem_array.sv
rtl/axi_mem_write.sv
rtl/axi_mem_read.sv
rtl/axi_mem_slave.sv
testbench/tb_axi_mem_slave.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and judge the result from sim.log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_axi_mem_slave -f verilog.f -o tb_sim > sim.log 2>&1 \
  && ./obj_dir/tb_sim >> sim.log 2>&1 \
  || { echo "Build or run failed, see sim.log"; exit 1; }

grep -q "^TB PASSED$" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed, see sim.log"; exit 1; }
